// ==== hdl/div_pkg.sv ====
// divide unit shared types: operation codes, register map, request/response and bus structs
`default_nettype none

package div_pkg;

    localparam int DATA_WIDTH_DEF = 32;

    // RISC-V M divide family
    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_t;

    typedef struct packed {
        div_op_t     op;
        logic [31:0] dividend;
        logic [31:0] divisor;
    } div_req_t;

    typedef struct packed {
        logic [31:0] result;
        logic        done;
    } div_resp_t;

    // wishbone classic, byte addressed
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

    localparam logic [3:0] REG_DIVIDEND = 4'h0;
    localparam logic [3:0] REG_DIVISOR  = 4'h4;
    localparam logic [3:0] REG_CTRL     = 4'h8;
    localparam logic [3:0] REG_RESULT   = 4'hC;

    localparam int CTRL_START_BIT = 4;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

`default_nettype wire

// ==== hdl/wb_div_regs.sv ====
// Wishbone classic slave holding the divider operands, control, status and result
`timescale 1ns/1ps
`default_nettype none

module wb_div_regs #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  div_pkg::wb_m2s_t    wb_i,
    output div_pkg::wb_s2m_t    wb_o,
    output div_pkg::div_req_t   req_o,
    output logic                start_o,
    input  div_pkg::div_resp_t  resp_i,
    input  wire                 busy_i
);
    import div_pkg::*;

    logic                  ack_q;
    logic                  start_q;
    logic                  done_q;
    logic [31:0]           result_q;
    logic [31:0]           rdat_q;
    logic [DATA_WIDTH-1:0] dividend_q;
    logic [DATA_WIDTH-1:0] divisor_q;
    div_op_t               op_q;

    logic        req_seen;
    logic        wr_ctrl;
    logic [31:0] status;
    logic [31:0] rdat;

    // new access only when no ack is pending
    assign req_seen = wb_i.cyc & wb_i.stb & ~ack_q;
    assign wr_ctrl  = req_seen & wb_i.we & (wb_i.adr == REG_CTRL);

    always_comb begin
        status                = '0;
        status[STAT_BUSY_BIT] = busy_i;
        status[STAT_DONE_BIT] = done_q;
    end

    always_comb begin
        case (wb_i.adr)
            REG_DIVIDEND: rdat = 32'(dividend_q);
            REG_DIVISOR:  rdat = 32'(divisor_q);
            REG_CTRL:     rdat = status;
            REG_RESULT:   rdat = result_q;
            default:      rdat = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            ack_q   <= req_seen;
            // start while busy is acked but dropped
            start_q <= wr_ctrl & wb_i.dat[CTRL_START_BIT] & ~busy_i;
            if (start_q) begin
                done_q <= 1'b0;
            end else if (resp_i.done) begin
                done_q   <= 1'b1;
                result_q <= resp_i.result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_seen) begin
            rdat_q <= rdat;
        end
        if (req_seen && wb_i.we) begin
            if (wb_i.adr == REG_DIVIDEND) begin
                dividend_q <= wb_i.dat[DATA_WIDTH-1:0];
            end
            if (wb_i.adr == REG_DIVISOR) begin
                divisor_q <= wb_i.dat[DATA_WIDTH-1:0];
            end
        end
        // op only changes when a division can start
        if (wr_ctrl && !busy_i) begin
            op_q <= div_op_t'(wb_i.dat[1:0]);
        end
    end

    assign wb_o.ack       = ack_q;
    assign wb_o.dat       = rdat_q;
    assign start_o        = start_q;
    assign req_o.op       = op_q;
    assign req_o.dividend = 32'(dividend_q);
    assign req_o.divisor  = 32'(divisor_q);

endmodule

`default_nettype wire

// ==== hdl/div_ctrl.sv ====
// divider sequencer: one-hot IDLE/START/CALC/END FSM with the zero and early-exit shortcuts
`timescale 1ns/1ps
`default_nettype none

module div_ctrl #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start_i,
    input  div_pkg::div_req_t     req_i,
    input  wire                   div_zero_i,
    input  wire                   early_exit_i,
    input  wire                   negate_i,
    input  wire                   last_i,
    input  wire  [DATA_WIDTH-1:0] final_i,
    output div_pkg::div_req_t     latched_req_o,
    output logic                  busy_o,
    output logic                  load_o,
    output logic                  step_o,
    output logic                  cnt_load_o,
    output logic                  cnt_en_o,
    output logic                  negate_o,
    output logic                  sel_rem_o,
    output div_pkg::div_resp_t    resp_o
);
    import div_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE  = 4'b0001,
        ST_START = 4'b0010,
        ST_CALC  = 4'b0100,
        ST_END   = 4'b1000
    } state_t;

    state_t                state_q;
    logic                  short_q;
    logic                  negate_q;
    logic [DATA_WIDTH-1:0] short_res_q;
    div_req_t              req_q;

    logic                  is_div_op;
    logic                  shortcut;
    logic [DATA_WIDTH-1:0] dividend_w;

    assign is_div_op  = (req_q.op == OP_DIV) || (req_q.op == OP_DIVU);
    assign shortcut   = div_zero_i | early_exit_i;
    assign dividend_w = req_q.dividend[DATA_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            short_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    short_q <= shortcut;
                    state_q <= shortcut ? ST_END : ST_CALC;
                end
                ST_CALC: begin
                    if (last_i) begin
                        state_q <= ST_END;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // request copy and shortcut result
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start_i) begin
            req_q <= req_i;
        end
        if (state_q == ST_START) begin
            negate_q <= negate_i;
            // divide by zero wins over early exit
            if (div_zero_i) begin
                short_res_q <= is_div_op ? '1 : dividend_w;
            end else begin
                short_res_q <= is_div_op ? '0 : dividend_w;
            end
        end
    end

    assign busy_o     = (state_q != ST_IDLE);
    assign load_o     = (state_q == ST_START) & ~shortcut;
    assign cnt_load_o = load_o;
    assign step_o     = (state_q == ST_CALC);
    assign cnt_en_o   = step_o;
    assign negate_o   = negate_q;
    assign sel_rem_o  = ~is_div_op;

    assign latched_req_o = req_q;
    assign resp_o.done   = (state_q == ST_END);
    assign resp_o.result = 32'(short_q ? short_res_q : final_i);

endmodule

`default_nettype wire

// ==== hdl/div_step_counter.sv ====
// down counter over the shift-subtract steps, flags the final one
`timescale 1ns/1ps
`default_nettype none

module div_step_counter #(
    parameter int DATA_WIDTH = 32
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  load_i,
    input  wire  en_i,
    output logic last_o
);
    localparam int CW = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

    logic [CW-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= CW'(DATA_WIDTH - 1);
        end else if (en_i && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign last_o = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== hdl/div_operand_prep.sv ====
// operand magnitudes, zero-divisor and early-exit detection, result sign decision
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep #(
    parameter int DATA_WIDTH = 32
) (
    input  div_pkg::div_req_t     req_i,
    output logic [DATA_WIDTH-1:0] dividend_mag_o,
    output logic [DATA_WIDTH-1:0] divisor_mag_o,
    output logic                  div_zero_o,
    output logic                  early_exit_o,
    output logic                  negate_o
);
    import div_pkg::*;

    logic [DATA_WIDTH-1:0] dividend;
    logic [DATA_WIDTH-1:0] divisor;
    logic                  is_signed;
    logic                  dvd_neg;
    logic                  dsr_neg;

    assign dividend  = req_i.dividend[DATA_WIDTH-1:0];
    assign divisor   = req_i.divisor[DATA_WIDTH-1:0];
    assign is_signed = (req_i.op == OP_DIV) || (req_i.op == OP_REM);

    // sign bits only count for the signed ops
    assign dvd_neg = is_signed & dividend[DATA_WIDTH-1];
    assign dsr_neg = is_signed & divisor[DATA_WIDTH-1];

    assign dividend_mag_o = dvd_neg ? -dividend : dividend;
    assign divisor_mag_o  = dsr_neg ? -divisor : divisor;

    assign div_zero_o   = (divisor == '0);
    assign early_exit_o = (dividend_mag_o < divisor_mag_o);

    // quotient sign from both operands, remainder follows the dividend
    assign negate_o = ((req_i.op == OP_DIV) & (dvd_neg ^ dsr_neg))
                    | ((req_i.op == OP_REM) & dvd_neg);

endmodule

`default_nettype wire

// ==== hdl/div_datapath.sv ====
// restoring shift-subtract datapath with final result select and sign fix
`timescale 1ns/1ps
`default_nettype none

module div_datapath #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   load_i,
    input  wire                   step_i,
    input  wire  [DATA_WIDTH-1:0] dividend_mag_i,
    input  wire  [DATA_WIDTH-1:0] divisor_mag_i,
    input  wire                   negate_i,
    input  wire                   sel_rem_i,
    output logic [DATA_WIDTH-1:0] final_o
);
    // quot_q starts as the dividend, quotient bits fill in from the lsb
    logic [DATA_WIDTH-1:0] quot_q;
    logic [DATA_WIDTH-1:0] rem_q;

    logic [DATA_WIDTH:0]   trial;
    logic [DATA_WIDTH:0]   diff;
    logic                  fits;
    logic [DATA_WIDTH-1:0] chosen;

    // next dividend bit into the partial remainder
    assign trial = {rem_q, quot_q[DATA_WIDTH-1]};
    assign diff  = trial - {1'b0, divisor_mag_i};
    // no borrow means the divisor fits
    assign fits  = ~diff[DATA_WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            quot_q <= '0;
            rem_q  <= '0;
        end else if (load_i) begin
            quot_q <= dividend_mag_i;
            rem_q  <= '0;
        end else if (step_i) begin
            quot_q <= {quot_q[DATA_WIDTH-2:0], fits};
            rem_q  <= fits ? diff[DATA_WIDTH-1:0] : trial[DATA_WIDTH-1:0];
        end
    end

    assign chosen  = sel_rem_i ? rem_q : quot_q;
    assign final_o = negate_i ? -chosen : chosen;

endmodule

`default_nettype wire

// ==== hdl/div_unit_top.sv ====
// memory-mapped divide unit: Wishbone register block driving the iterative divider
`timescale 1ns/1ps
`default_nettype none

module div_unit_top #(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH_DEF
) (
    input  wire               clk,
    input  wire               rst_n,
    input  div_pkg::wb_m2s_t  wb_i,
    output div_pkg::wb_s2m_t  wb_o
);
    import div_pkg::*;

    div_req_t              req;
    div_req_t              latched_req;
    div_resp_t             resp;
    logic                  start;
    logic                  busy;
    logic                  load;
    logic                  step;
    logic                  cnt_load;
    logic                  cnt_en;
    logic                  last;
    logic                  div_zero;
    logic                  early_exit;
    logic                  negate_prep;
    logic                  negate_dp;
    logic                  sel_rem;
    logic [DATA_WIDTH-1:0] dividend_mag;
    logic [DATA_WIDTH-1:0] divisor_mag;
    logic [DATA_WIDTH-1:0] final_res;

    wb_div_regs #(.DATA_WIDTH(DATA_WIDTH)) wb_div_regs_i (
        .clk(clk), .rst_n(rst_n), .wb_i(wb_i), .wb_o(wb_o),
        .req_o(req), .start_o(start), .resp_i(resp), .busy_i(busy)
    );

    div_ctrl #(.DATA_WIDTH(DATA_WIDTH)) div_ctrl_i (
        .clk(clk), .rst_n(rst_n), .start_i(start), .req_i(req),
        .div_zero_i(div_zero), .early_exit_i(early_exit), .negate_i(negate_prep),
        .last_i(last), .final_i(final_res), .latched_req_o(latched_req),
        .busy_o(busy), .load_o(load), .step_o(step), .cnt_load_o(cnt_load),
        .cnt_en_o(cnt_en), .negate_o(negate_dp), .sel_rem_o(sel_rem), .resp_o(resp)
    );

    div_step_counter #(.DATA_WIDTH(DATA_WIDTH)) div_step_counter_i (
        .clk(clk), .rst_n(rst_n), .load_i(cnt_load), .en_i(cnt_en), .last_o(last)
    );

    div_operand_prep #(.DATA_WIDTH(DATA_WIDTH)) div_operand_prep_i (
        .req_i(latched_req), .dividend_mag_o(dividend_mag), .divisor_mag_o(divisor_mag),
        .div_zero_o(div_zero), .early_exit_o(early_exit), .negate_o(negate_prep)
    );

    div_datapath #(.DATA_WIDTH(DATA_WIDTH)) div_datapath_i (
        .clk(clk), .rst_n(rst_n), .load_i(load), .step_i(step),
        .dividend_mag_i(dividend_mag), .divisor_mag_i(divisor_mag),
        .negate_i(negate_dp), .sel_rem_i(sel_rem), .final_o(final_res)
    );

endmodule

`default_nettype wire

// ==== tb/div_unit_properties.sv ====
// handshake and controller assertions for the divide unit bound into the register block
`timescale 1ns/1ps
`default_nettype none

module div_unit_properties (
    input wire clk,
    input wire rst_n,
    input wire busy_i,
    input wire done_i,
    input wire ack_i,
    input wire stb_i,
    input wire cyc_i
);

    // sync reset returns the FSM to IDLE
    busy_low_after_reset: assert property (@(posedge clk) !rst_n |=> !busy_i)
        else $error("busy high right after reset");

    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else $error("done held for more than one cycle");

    ack_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |=> !ack_i)
        else $error("ack held for two cycles");

    // classic master keeps the request up until it has seen ack
    ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |-> (cyc_i && stb_i))
        else $error("ack without cyc and stb");

endmodule

// controller outputs are visible here as the register block's inputs
bind wb_div_regs div_unit_properties div_unit_properties_i (
    .clk   (clk),
    .rst_n (rst_n),
    .busy_i(busy_i),
    .done_i(resp_i.done),
    .ack_i (ack_q),
    .stb_i (wb_i.stb),
    .cyc_i (wb_i.cyc)
);

`default_nettype wire

// ==== tb/tb_div_unit.sv ====
// testbench for the Wishbone divide unit running a table of operations against RISC-V M results
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;
    import div_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int NUM_RANDOM = 16;
    localparam int ROW_CYCLES = 60;

    typedef struct packed {
        div_op_t     op;
        logic [31:0] dividend;
        logic [31:0] divisor;
        logic [31:0] expected;
    } row_t;

    logic    clk;
    logic    rst_n;
    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m;
    row_t    rows[$];
    logic    rows_ready;
    int      errors;
    int      checks;

    div_unit_top #(
        .DATA_WIDTH(DATA_WIDTH)
    ) div_unit_top_i (
        .clk  (clk),
        .rst_n(rst_n),
        .wb_i (wb_m2s),
        .wb_o (wb_s2m)
    );

    always #4 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s, read 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    // outputs sampled 1 ns after the edge
    task automatic wait_ack();
        @(posedge clk);
        #1;
        while (!wb_s2m.ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    // request held through the ack cycle and dropped after the next edge
    task automatic release_bus();
        @(posedge clk);
        #1;
        wb_m2s = '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        wb_m2s.cyc = 1'b1;
        wb_m2s.stb = 1'b1;
        wb_m2s.we  = 1'b1;
        wb_m2s.adr = adr;
        wb_m2s.dat = dat;
        wait_ack();
        release_bus();
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        wb_m2s.cyc = 1'b1;
        wb_m2s.stb = 1'b1;
        wb_m2s.we  = 1'b0;
        wb_m2s.adr = adr;
        wb_m2s.dat = '0;
        wait_ack();
        dat = wb_s2m.dat;
        release_bus();
    endtask

    function automatic logic [31:0] ctrl_word(input div_op_t op);
        logic [31:0] w;
        w                 = '0;
        w[1:0]            = op;
        w[CTRL_START_BIT] = 1'b1;
        return w;
    endfunction

    function automatic string op_name(input div_op_t op);
        case (op)
            OP_DIV:  return "div";
            OP_DIVU: return "divu";
            OP_REM:  return "rem";
            default: return "remu";
        endcase
    endfunction

    // RISC-V M rules with zero divisor and signed overflow handled first
    function automatic logic [31:0] model_result(input div_op_t op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               overflow;
        logic [31:0]        res;
        sa       = a;
        sb       = b;
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        if (b == 32'h0) begin
            res = (op == OP_DIV || op == OP_DIVU) ? 32'hFFFF_FFFF : a;
        end else if (overflow && op == OP_DIV) begin
            res = a;
        end else if (overflow && op == OP_REM) begin
            res = 32'h0;
        end else begin
            case (op)
                OP_DIV:  res = 32'(sa / sb);
                OP_DIVU: res = a / b;
                OP_REM:  res = 32'(sa % sb);
                default: res = a % b;
            endcase
        end
        return res;
    endfunction

    function automatic void add_row(input div_op_t op, input logic [31:0] a,
                                    input logic [31:0] b, input logic [31:0] exp_val);
        row_t r;
        r.op       = op;
        r.dividend = a;
        r.divisor  = b;
        r.expected = exp_val;
        rows.push_back(r);
    endfunction

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [1:0]  op_bits;
        // sign combinations
        add_row(OP_DIV,  32'd100,       32'd7,         32'd14);
        add_row(OP_DIV,  32'hFFFF_FF9C, 32'd7,         32'hFFFF_FFF2);
        add_row(OP_DIV,  32'd100,       32'hFFFF_FFF9, 32'hFFFF_FFF2);
        add_row(OP_DIV,  32'hFFFF_FF9C, 32'hFFFF_FFF9, 32'd14);
        add_row(OP_DIV,  32'hFFFF_FFF9, 32'd7,         32'hFFFF_FFFF);
        add_row(OP_REM,  32'd100,       32'd7,         32'd2);
        add_row(OP_REM,  32'hFFFF_FF9C, 32'd7,         32'hFFFF_FFFE);
        add_row(OP_REM,  32'd100,       32'hFFFF_FFF9, 32'd2);
        add_row(OP_REM,  32'hFFFF_FF9C, 32'hFFFF_FFF9, 32'hFFFF_FFFE);
        add_row(OP_DIV,  32'h7FFF_FFFF, 32'd3,         32'h2AAA_AAAA);
        add_row(OP_REM,  32'h7FFF_FFFF, 32'd3,         32'd1);
        add_row(OP_DIVU, 32'hFFFF_FFF0, 32'd16,        32'h0FFF_FFFF);
        add_row(OP_REMU, 32'hFFFF_FFF0, 32'd7,         32'd2);
        add_row(OP_DIVU, 32'd1000,      32'd10,        32'd100);
        add_row(OP_REMU, 32'd1003,      32'd10,        32'd3);
        // zero divisor
        add_row(OP_DIV,  32'd1234,      32'h0,         32'hFFFF_FFFF);
        add_row(OP_DIV,  32'hFFFF_FF85, 32'h0,         32'hFFFF_FFFF);
        add_row(OP_DIVU, 32'hFFFF_FF85, 32'h0,         32'hFFFF_FFFF);
        add_row(OP_REM,  32'hFFFF_FF85, 32'h0,         32'hFFFF_FF85);
        add_row(OP_REMU, 32'd1234,      32'h0,         32'd1234);
        // signed overflow
        add_row(OP_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
        add_row(OP_REM,  32'h8000_0000, 32'hFFFF_FFFF, 32'h0);
        // dividend magnitude below divisor magnitude
        add_row(OP_DIV,  32'd5,         32'd9,         32'h0);
        add_row(OP_REM,  32'hFFFF_FFFB, 32'd9,         32'hFFFF_FFFB);
        add_row(OP_DIV,  32'hFFFF_FFFB, 32'hFFFF_FFF7, 32'h0);
        add_row(OP_REMU, 32'd3,         32'h8000_0000, 32'd3);
        add_row(OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0);
        add_row(OP_REMU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
        // random divisor widths give both full divisions and early exits
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op_bits = 2'($urandom % 4);
            a       = $urandom;
            b       = $urandom >> ($urandom % 32);
            add_row(div_op_t'(op_bits), a, b, model_result(div_op_t'(op_bits), a, b));
        end
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!status[STAT_DONE_BIT]) begin
            wb_read(REG_CTRL, status);
        end
    endtask

    task automatic run_division(input row_t row, output logic [31:0] result);
        wb_write(REG_DIVIDEND, row.dividend);
        wb_write(REG_DIVISOR, row.divisor);
        wb_write(REG_CTRL, ctrl_word(row.op));
        wait_done();
        wb_read(REG_RESULT, result);
    endtask

    // busy and done bits through reset, a run, an ignored start and a restart
    task automatic check_status_flow();
        logic [31:0] data;
        wb_read(REG_CTRL, data);
        check_value(data, 32'h0, "status after reset");
        wb_read(REG_RESULT, data);
        check_value(data, 32'h0, "result after reset");
        wb_write(REG_DIVIDEND, 32'hFFFF_FFFF);
        wb_write(REG_DIVISOR, 32'd3);
        wb_write(REG_CTRL, ctrl_word(OP_DIVU));
        wb_read(REG_CTRL, data);
        check_value(data, 32'h1, "status while running");
        wb_write(REG_CTRL, ctrl_word(OP_REMU));
        wait_done();
        wb_read(REG_CTRL, data);
        check_value(data, 32'h2, "status after completion");
        wb_read(REG_RESULT, data);
        check_value(data, 32'h5555_5555, "result after start written while busy");
        wb_write(REG_CTRL, ctrl_word(OP_REMU));
        wb_read(REG_CTRL, data);
        check_value(data, 32'h1, "status after restart");
        wait_done();
        wb_read(REG_RESULT, data);
        check_value(data, 32'h0, "remainder after restart");
    endtask

    initial begin
        row_t        row;
        logic [31:0] result;
        clk        = 1'b0;
        rst_n      = 1'b0;
        wb_m2s     = '0;
        errors     = 0;
        checks     = 0;
        rows_ready = 1'b0;
        void'($urandom(87));
        build_table();
        rows_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_status_flow();
        foreach (rows[i]) begin
            row = rows[i];
            run_division(row, result);
            check_value(result, row.expected,
                        $sformatf("row %0d %s 0x%08h by 0x%08h", i, op_name(row.op),
                                  row.dividend, row.divisor));
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // budget per table row plus room for the status sequence
    initial begin
        wait (rows_ready);
        repeat ((rows.size() + 8) * ROW_CYCLES) @(posedge clk);
        $display("Timeout: the divide unit did not finish the table in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/div_pkg.sv
hdl/wb_div_regs.sv
hdl/div_ctrl.sv
hdl/div_step_counter.sv
hdl/div_operand_prep.sv
hdl/div_datapath.sv
hdl/div_unit_top.sv
tb/div_unit_properties.sv
tb/tb_div_unit.sv

// ==== Makefile ====
# Verilator build and run of the divide unit testbench

TOP := tb_div_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f filelist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
